// File: Bender.yml
package:
  name: dma_write

sources:
  # RTL
  - files:
      - dma_pkg.sv
      - transfer_controller.sv
      - dma_regs.sv
      - axi_write_master.sv
      - dma_write_top.sv
  # Testbench
  - target: test
    files:
      - tb_dma_checker.sv
      - tb_dma_write.sv

// File: axi_write_master.sv
module axi_write_master #(
   parameter int addr_w = 32
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       start,
   input  logic [addr_w-1:0]          burst_addr,
   input  logic [7:0]                 burst_len,
   input  logic [dma_pkg::strb_w-1:0] first_strb,
   input  logic [dma_pkg::strb_w-1:0] last_strb,
   input  logic                       last_burst,
   output logic                       burst_accept,
   output logic [addr_w-1:0]          awaddr,
   output logic [7:0]                 awlen,
   output logic                       awvalid,
   input  logic                       awready,
   output logic [dma_pkg::data_w-1:0] wdata,
   output logic [dma_pkg::strb_w-1:0] wstrb,
   output logic                       wlast,
   output logic                       wvalid,
   input  logic                       wready,
   input  logic [1:0]                 bresp,
   input  logic                       bvalid,
   output logic                       bready,
   input  logic [dma_pkg::data_w-1:0] in_data,
   input  logic                       in_valid,
   output logic                       in_ready,
   output logic                       busy,
   output logic                       done,
   output logic                       error
);

   localparam int out_w = 8;   // Outstanding B responses

   // Two-entry burst queue, pushed at AW and popped by the W side
   logic [7:0]                 q_len   [2];
   logic                       q_first [2];
   logic                       q_last  [2];
   logic [dma_pkg::strb_w-1:0] q_fstrb [2];
   logic [dma_pkg::strb_w-1:0] q_lstrb [2];
   logic                       q_wr;
   logic                       q_rd;
   logic [1:0]                 q_cnt;
   logic                       q_pop;

   logic                       aw_hs;
   logic                       aw_first;   // Next AW carries the first burst
   logic                       aw_done;    // Final burst already accepted
   logic                       w_load;     // Stream word taken into the W register
   logic [7:0]                 beat_cnt;
   logic                       beat_last;
   logic [dma_pkg::strb_w-1:0] beat_strb;
   logic                       b_hs;
   logic                       b_final;
   logic [out_w-1:0]           b_out;

   assign aw_hs        = awvalid && awready;
   assign burst_accept = aw_hs;
   assign awaddr       = burst_addr;   // Registered in the controller
   assign awlen        = burst_len;

   assign bready = 1'b1;
   assign b_hs   = bvalid && bready;

   // W register refills whenever it is empty or being drained
   assign in_ready  = (q_cnt != 2'd0) && (!wvalid || wready);
   assign w_load    = in_ready && in_valid;
   assign beat_last = (beat_cnt == q_len[q_rd]);
   assign q_pop     = w_load && beat_last;

   always_comb begin
      beat_strb = '1;
      if (q_first[q_rd] && beat_cnt == 8'd0) begin
         beat_strb = beat_strb & q_fstrb[q_rd];
      end
      // Single-beat transfers take both masks
      if (q_last[q_rd] && beat_last) begin
         beat_strb = beat_strb & q_lstrb[q_rd];
      end
   end

   assign b_final = b_hs && aw_done && (b_out == out_w'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         awvalid  <= 1'b0;
         aw_first <= 1'b0;
         aw_done  <= 1'b0;
         q_wr     <= 1'b0;
         q_rd     <= 1'b0;
         q_cnt    <= 2'd0;
         beat_cnt <= 8'd0;
         wvalid   <= 1'b0;
         b_out    <= '0;
         busy     <= 1'b0;
         done     <= 1'b0;
         error    <= 1'b0;
      end else begin
         // AW side, one idle cycle after every handshake
         if (start) begin
            awvalid  <= 1'b1;
            aw_first <= 1'b1;
            aw_done  <= 1'b0;
         end else if (aw_hs) begin
            awvalid  <= 1'b0;
            aw_first <= 1'b0;
            if (last_burst) begin
               aw_done <= 1'b1;
            end
         end else if (busy && !awvalid && !aw_done && q_cnt != 2'd2 &&
                      b_out != {out_w{1'b1}}) begin
            awvalid <= 1'b1;
         end

         if (aw_hs) begin
            q_wr <= !q_wr;
         end
         if (q_pop) begin
            q_rd <= !q_rd;
         end
         q_cnt <= q_cnt + 2'(aw_hs) - 2'(q_pop);

         // W side
         if (w_load) begin
            wvalid   <= 1'b1;
            beat_cnt <= beat_last ? 8'd0 : beat_cnt + 8'd1;
         end else if (wready) begin
            wvalid <= 1'b0;
         end

         // B side and completion
         b_out <= b_out + out_w'(aw_hs) - out_w'(b_hs);
         done  <= b_final;
         if (start) begin
            busy <= 1'b1;
         end else if (b_final) begin
            busy <= 1'b0;
         end
         if (start) begin
            error <= 1'b0;
         end else if (b_hs && bresp != dma_pkg::resp_okay) begin
            error <= 1'b1;   // Transfer keeps running
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         q_len[q_wr]   <= burst_len;
         q_first[q_wr] <= aw_first;
         q_last[q_wr]  <= last_burst;
         q_fstrb[q_wr] <= first_strb;
         q_lstrb[q_wr] <= last_strb;
      end
      if (w_load) begin
         wdata <= in_data;
         wstrb <= beat_strb;
         wlast <= beat_last;
      end
   end

endmodule

// File: dma_input.txt
// Columns in hex: start address, length in bytes, expected AXI burst count
// One transfer per line
00001000 00000040 00000001
00002003 00000001 00000001
00002101 00000002 00000001
00003002 00000003 00000001
00000ff0 00000040 00000002
00004000 00000800 00000002
00005001 00000c00 00000004
00006ffe 00000010 00000002
00007c02 00000900 00000003
00009ffc 00000004 00000001

// File: dma_pkg.sv
package dma_pkg;

   // Bus geometry, one 32-bit word per beat
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   // AXI4 burst rules
   localparam int boundary_bytes = 4096;  // No burst may cross a 4 KB page
   localparam int max_beats      = 256;

   localparam logic [2:0] axi_size_word  = 3'b010;  // 4 bytes per beat
   localparam logic [1:0] axi_burst_incr = 2'b01;
   localparam logic [1:0] resp_okay      = 2'b00;

   // Wishbone word offsets
   localparam logic [1:0] reg_ctrl   = 2'd0;
   localparam logic [1:0] reg_addr   = 2'd1;
   localparam logic [1:0] reg_len    = 2'd2;
   localparam logic [1:0] reg_status = 2'd3;

   localparam int ctrl_start_bit = 0;  // Self-clearing

   // Status register layout
   localparam int status_busy_bit  = 0;
   localparam int status_done_bit  = 1;
   localparam int status_error_bit = 2;

endpackage

// File: dma_regs.sv
module dma_regs #(
   parameter int addr_w = 32,
   parameter int len_w  = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  logic [1:0]        wb_adr,
   input  logic [31:0]       wb_dat_w,
   output logic [31:0]       wb_dat_r,
   output logic              wb_ack,
   output logic [addr_w-1:0] xfer_addr,
   output logic [len_w-1:0]  xfer_len,
   output logic              start,
   input  logic              busy,
   input  logic              done,
   input  logic              error
);

   logic        req;        // New access, not yet acknowledged
   logic        wr;
   logic        start_req;
   logic        done_bit;   // Sticky until the next start
   logic        error_bit;
   logic [31:0] status;

   assign req = wb_cyc && wb_stb && !wb_ack;
   assign wr  = req && wb_we;

   // Start is only taken while idle
   assign start_req = wr && (wb_adr == dma_pkg::reg_ctrl) &&
                      wb_dat_w[dma_pkg::ctrl_start_bit] && !busy;

   always_comb begin
      status = '0;
      status[dma_pkg::status_busy_bit]  = busy;
      status[dma_pkg::status_done_bit]  = done_bit;
      status[dma_pkg::status_error_bit] = error_bit;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wb_ack    <= 1'b0;
         start     <= 1'b0;
         done_bit  <= 1'b0;
         error_bit <= 1'b0;
      end else begin
         wb_ack <= req;
         start  <= start_req;   // Lines up with the ack of the write

         if (start) begin
            done_bit  <= 1'b0;
            error_bit <= 1'b0;
         end else begin
            if (done) begin
               done_bit <= 1'b1;
            end
            if (error) begin
               error_bit <= 1'b1;
            end
         end
      end
   end

   // Transfer setup, frozen while the engine runs
   always_ff @(posedge clk) begin
      if (wr && !busy) begin
         if (wb_adr == dma_pkg::reg_addr) begin
            xfer_addr <= addr_w'(wb_dat_w);
         end
         if (wb_adr == dma_pkg::reg_len) begin
            xfer_len <= len_w'(wb_dat_w);
         end
      end
   end

   // Read data is presented together with ack
   always_ff @(posedge clk) begin
      if (req) begin
         case (wb_adr)
            dma_pkg::reg_addr:   wb_dat_r <= 32'(xfer_addr);
            dma_pkg::reg_len:    wb_dat_r <= 32'(xfer_len);
            dma_pkg::reg_status: wb_dat_r <= status;
            default:             wb_dat_r <= '0;   // Control reads as zero
         endcase
      end
   end

endmodule

// File: dma_write_top.sv
module dma_write_top #(
   parameter int addr_w = 32,
   parameter int len_w  = 32
) (
   input  logic                       clk,
   input  logic                       rst,
   // Wishbone configuration port
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [1:0]                 wb_adr,
   input  logic [31:0]                wb_dat_w,
   output logic [31:0]                wb_dat_r,
   output logic                       wb_ack,
   // Word stream in
   input  logic [dma_pkg::data_w-1:0] in_data,
   input  logic                       in_valid,
   output logic                       in_ready,
   // AXI4 write channels
   output logic [addr_w-1:0]          awaddr,
   output logic [7:0]                 awlen,
   output logic [2:0]                 awsize,
   output logic [1:0]                 awburst,
   output logic                       awvalid,
   input  logic                       awready,
   output logic [dma_pkg::data_w-1:0] wdata,
   output logic [dma_pkg::strb_w-1:0] wstrb,
   output logic                       wlast,
   output logic                       wvalid,
   input  logic                       wready,
   input  logic [1:0]                 bresp,
   input  logic                       bvalid,
   output logic                       bready,
   output logic                       done
);

   logic [addr_w-1:0]          xfer_addr;
   logic [len_w-1:0]           xfer_len;
   logic                       start;
   logic                       busy;
   logic                       error;
   logic [addr_w-1:0]          burst_addr;
   logic [7:0]                 burst_len;
   logic [dma_pkg::strb_w-1:0] first_strb;
   logic [dma_pkg::strb_w-1:0] last_strb;
   logic                       last_burst;
   logic                       burst_accept;

   // Full-word INCR bursts only
   assign awsize  = dma_pkg::axi_size_word;
   assign awburst = dma_pkg::axi_burst_incr;

   dma_regs #(
      .addr_w (addr_w),
      .len_w  (len_w)
   ) u_regs (
      .clk       (clk),
      .rst       (rst),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .xfer_addr (xfer_addr),
      .xfer_len  (xfer_len),
      .start     (start),
      .busy      (busy),
      .done      (done),
      .error     (error)
   );

   transfer_controller #(
      .addr_w (addr_w),
      .len_w  (len_w)
   ) u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .xfer_addr    (xfer_addr),
      .xfer_len     (xfer_len),
      .burst_accept (burst_accept),
      .burst_addr   (burst_addr),
      .burst_len    (burst_len),
      .first_strb   (first_strb),
      .last_strb    (last_strb),
      .last_burst   (last_burst)
   );

   axi_write_master #(
      .addr_w (addr_w)
   ) u_master (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .burst_addr   (burst_addr),
      .burst_len    (burst_len),
      .first_strb   (first_strb),
      .last_strb    (last_strb),
      .last_burst   (last_burst),
      .burst_accept (burst_accept),
      .awaddr       (awaddr),
      .awlen        (awlen),
      .awvalid      (awvalid),
      .awready      (awready),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wlast        (wlast),
      .wvalid       (wvalid),
      .wready       (wready),
      .bresp        (bresp),
      .bvalid       (bvalid),
      .bready       (bready),
      .in_data      (in_data),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .busy         (busy),
      .done         (done),
      .error        (error)
   );

endmodule

// File: tb_dma_checker.sv
module tb_dma_checker (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] awaddr,
   input  logic [7:0]  awlen,
   input  logic [2:0]  awsize,
   input  logic [1:0]  awburst,
   input  logic        awvalid,
   input  logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wlast,
   input  logic        wvalid,
   input  logic        wready,
   input  logic        bvalid,
   input  logic        bready,
   input  logic [31:0] in_data,
   input  logic        in_valid,
   input  logic        in_ready,
   input  logic        done,
   input  logic        test_begin,   // One-cycle marks around each transfer
   input  logic        test_end,
   input  logic        all_done,
   input  logic [31:0] exp_addr,
   input  logic [31:0] exp_len,
   input  logic [31:0] exp_bursts,
   input  logic        exp_error,
   input  logic [31:0] status_word,  // Status register read after done
   output int          tests_failed
);
   timeunit 1ns;
   timeprecision 1ps;

   int          test_num = 0;
   int          tests_passed = 0;
   int          errors;
   int          aw_seen;
   int          b_seen;
   int          done_seen;
   int          beat_in_burst;
   int          beat_total;
   int          byte_sum;
   int          total_beats;
   logic [31:0] next_awaddr;
   logic [31:0] last_byte;
   logic [3:0]  first_mask;
   logic [3:0]  last_mask;
   int          burst_q [$];    // awlen of bursts still owed W beats
   logic [31:0] stream_q [$];   // Stream words not yet seen on W

   initial tests_failed = 0;

   task automatic flag_error(input string msg);
      $display("Error at %0d ns: test %0d, %s", $time, test_num, msg);
      errors++;
   endtask

   task automatic check_aw();
      if (aw_seen == 0) next_awaddr = {exp_addr[31:2], 2'b00};
      if (awaddr != next_awaddr)
         flag_error($sformatf("burst %0d awaddr %h, expected %h", aw_seen, awaddr, next_awaddr));
      if (awsize != 3'b010)
         flag_error($sformatf("awsize %b, expected 4-byte beats", awsize));
      if (awburst != 2'b01)
         flag_error($sformatf("awburst %b, expected INCR", awburst));
      if (int'(awaddr[11:0]) + 4 * (int'(awlen) + 1) > 4096)
         flag_error($sformatf("burst at %h with awlen %0d crosses 4 KB", awaddr, awlen));
      burst_q.push_back(int'(awlen));
      next_awaddr = awaddr + 4 * (32'(awlen) + 1);
      aw_seen++;
   endtask

   task automatic check_w();
      logic [3:0]  exp_strb;
      logic [31:0] exp_data;
      int          cur_len;
      if (burst_q.size() == 0) begin
         flag_error("W beat without an accepted burst");
         return;
      end
      cur_len = burst_q[0];
      if (wlast != (beat_in_burst == cur_len))
         flag_error($sformatf("wlast %b on beat %0d of %0d", wlast, beat_in_burst, cur_len + 1));
      exp_strb = 4'hf;
      if (beat_total == 0) exp_strb = exp_strb & first_mask;
      if (beat_total == total_beats - 1) exp_strb = exp_strb & last_mask;
      if (wstrb != exp_strb)
         flag_error($sformatf("beat %0d wstrb %b, expected %b", beat_total, wstrb, exp_strb));
      byte_sum += $countones(wstrb);
      if (stream_q.size() == 0) begin
         flag_error("W beat with no stream word behind it");
      end else begin
         exp_data = stream_q.pop_front();
         if (wdata != exp_data)
            flag_error($sformatf("beat %0d wdata %h, expected %h", beat_total, wdata, exp_data));
      end
      if (beat_in_burst == cur_len) begin
         void'(burst_q.pop_front());
         beat_in_burst = 0;
      end else begin
         beat_in_burst++;
      end
      beat_total++;
   endtask

   task automatic close_test();
      if (aw_seen != exp_bursts)
         flag_error($sformatf("%0d bursts, expected %0d", aw_seen, exp_bursts));
      if (beat_total != total_beats)
         flag_error($sformatf("%0d W beats, expected %0d", beat_total, total_beats));
      if (byte_sum != exp_len)
         flag_error($sformatf("%0d strobed bytes, expected %0d", byte_sum, exp_len));
      if (burst_q.size() != 0 || beat_in_burst != 0)
         flag_error("an accepted burst never got all its W beats");
      if (stream_q.size() != 0)
         flag_error("stream words were taken but never written");
      if (b_seen != aw_seen)
         flag_error($sformatf("%0d B responses for %0d bursts", b_seen, aw_seen));
      if (done_seen != 1)
         flag_error($sformatf("done pulsed %0d times", done_seen));
      if (status_word[dma_pkg::status_busy_bit] || !status_word[dma_pkg::status_done_bit])
         flag_error($sformatf("status %h, expected done set and busy clear", status_word));
      if (status_word[dma_pkg::status_error_bit] != exp_error)
         flag_error($sformatf("status error bit %b, expected %b",
                              status_word[dma_pkg::status_error_bit], exp_error));
      if (errors == 0) begin
         tests_passed++;
         $display("test %0d: addr %h len %0d, %0d bursts, ok", test_num, exp_addr, exp_len, aw_seen);
      end else begin
         tests_failed++;
         $display("test %0d: addr %h len %0d, %0d errors", test_num, exp_addr, exp_len, errors);
      end
      test_num++;
   endtask

   // Values at the falling edge are the ones the next rising edge acts on
   always @(negedge clk) begin
      if (!rst) begin
         if (test_begin) begin
            errors        = 0;
            aw_seen       = 0;
            b_seen        = 0;
            done_seen     = 0;
            beat_in_burst = 0;
            beat_total    = 0;
            byte_sum      = 0;
            burst_q.delete();
            stream_q.delete();
            last_byte   = exp_addr + exp_len - 1;
            first_mask  = 4'hf << exp_addr[1:0];
            last_mask   = 4'hf >> (3 - last_byte[1:0]);   // Lanes up to the final byte
            total_beats = int'((last_byte >> 2) - (exp_addr >> 2)) + 1;
         end
         if (in_valid && in_ready) stream_q.push_back(in_data);
         if (awvalid && awready) check_aw();
         if (wvalid && wready) check_w();
         if (bvalid && bready) b_seen++;
         if (done) done_seen++;
         if (test_end) close_test();
         if (all_done) $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      end
   end

endmodule

// File: tb_dma_write.sv
module tb_dma_write;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_tests     = 10;
   localparam int slverr_test = 6;      // Transfer answered with SLVERR
   localparam int test_cycles = 4000;

   logic        clk;
   logic        rst;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [1:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic [31:0] in_data;
   logic        in_valid;
   logic        in_ready;
   logic [31:0] awaddr;
   logic [7:0]  awlen;
   logic [2:0]  awsize;
   logic [1:0]  awburst;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wlast;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic        done;

   logic [31:0] vectors [0:3*n_tests-1];   // Address, length, burst count
   logic        test_begin;
   logic        test_end;
   logic        all_done;
   logic [31:0] exp_addr;
   logic [31:0] exp_len;
   logic [31:0] exp_bursts;
   logic        exp_error;
   logic [31:0] status_word;
   int          tests_failed;
   int          cur_test;
   int          pending_b;                 // Bursts owed a B response
   logic [31:0] rand_state;
   logic        active;
   logic        in_taken;
   logic        wlast_taken;
   logic        b_taken;

   dma_write_top #(
      .addr_w (32),
      .len_w  (32)
   ) u_dma_write_top (
      .clk (clk), .rst (rst),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .in_data (in_data), .in_valid (in_valid), .in_ready (in_ready),
      .awaddr (awaddr), .awlen (awlen), .awsize (awsize), .awburst (awburst),
      .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
      .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .done (done)
   );

   tb_dma_checker u_checker (
      .clk (clk), .rst (rst),
      .awaddr (awaddr), .awlen (awlen), .awsize (awsize), .awburst (awburst),
      .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
      .bvalid (bvalid), .bready (bready),
      .in_data (in_data), .in_valid (in_valid), .in_ready (in_ready),
      .done (done),
      .test_begin (test_begin), .test_end (test_end), .all_done (all_done),
      .exp_addr (exp_addr), .exp_len (exp_len), .exp_bursts (exp_bursts),
      .exp_error (exp_error), .status_word (status_word),
      .tests_failed (tests_failed)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Called and returns 1 ns past a rising edge
   task automatic write_register(input logic [1:0] adr, input logic [31:0] data);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = data;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_register(input logic [1:0] adr, output logic [31:0] data);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      data = wb_dat_r;
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic wait_for_done();
      @(negedge clk);
      while (!done) @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   // AXI slave and stream source draw their stalls from one generator
   always begin
      @(negedge clk);
      active      = !rst;
      in_taken    = in_valid && in_ready;
      wlast_taken = wvalid && wready && wlast;
      b_taken     = bvalid && bready;
      @(posedge clk);
      #1;
      if (active) begin
         rand_state = next_random(rand_state);
         awready    = rand_state[31:29] != 3'd0;
         wready     = rand_state[28:26] > 3'd1;
         if (!in_valid || in_taken) begin
            in_valid   = rand_state[25:23] != 3'd0;
            rand_state = next_random(rand_state);
            in_data    = rand_state;
         end
         if (b_taken) pending_b--;
         if (wlast_taken) pending_b++;
         bvalid = pending_b != 0;
         bresp  = (cur_test == slverr_test) ? 2'b10 : dma_pkg::resp_okay;
      end
   end

   initial begin
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
      {in_data, in_valid, awready, wready, bresp, bvalid} = '0;
      {test_begin, test_end, all_done, exp_error} = '0;
      {exp_addr, exp_len, exp_bursts, status_word} = '0;
      cur_test   = 0;
      pending_b  = 0;
      rand_state = 32'd54;
      $readmemh("dma_input.txt", vectors);
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int t = 0; t < n_tests; t++) begin
         cur_test   = t;
         exp_addr   = vectors[3*t];
         exp_len    = vectors[3*t+1];
         exp_bursts = vectors[3*t+2];
         exp_error  = (t == slverr_test);
         test_begin = 1'b1;
         @(posedge clk);
         #1;
         test_begin = 1'b0;
         write_register(dma_pkg::reg_addr, exp_addr);
         write_register(dma_pkg::reg_len, exp_len);
         write_register(dma_pkg::reg_ctrl, 32'd1 << dma_pkg::ctrl_start_bit);
         wait_for_done();
         read_register(dma_pkg::reg_status, status_word);
         test_end = 1'b1;
         @(posedge clk);
         #1;
         test_end = 1'b0;
      end
      all_done = 1'b1;
      @(posedge clk);
      #1;
      all_done = 1'b0;
      @(posedge clk);
      #1;
      if (tests_failed == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog sized from the number of transfers
   initial begin
      repeat (n_tests * test_cycles + 1000) @(posedge clk);
      $display("Timeout: the DMA did not finish all %0d transfers in time", n_tests);
      $display("Test failed");
      $finish;
   end

endmodule

// File: transfer_controller.sv
module transfer_controller #(
   parameter int addr_w = 32,
   parameter int len_w  = 32
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       start,
   input  logic [addr_w-1:0]          xfer_addr,   // Held while busy
   input  logic [len_w-1:0]           xfer_len,    // Bytes, held while busy
   input  logic                       burst_accept,
   output logic [addr_w-1:0]          burst_addr,
   output logic [7:0]                 burst_len,   // Beats minus one
   output logic [dma_pkg::strb_w-1:0] first_strb,
   output logic [dma_pkg::strb_w-1:0] last_strb,
   output logic                       last_burst
);

   localparam int page_w = $clog2(dma_pkg::boundary_bytes);
   localparam int span_w = page_w + 1;                 // Holds a full page count
   localparam int lane_w = $clog2(dma_pkg::strb_w);

   logic [len_w-1:0]  remain;    // Bytes not yet covered by an accepted burst
   logic              first;     // Next burst is the first of the transfer
   logic [span_w-1:0] lead;      // Empty lanes ahead of the first byte
   logic [span_w-1:0] to_bound;
   logic [span_w-1:0] to_limit;
   logic [span_w-1:0] cap;
   logic [len_w-1:0]  size;      // Data bytes carried by this burst
   logic [len_w-1:0]  span_end;
   logic [lane_w-1:0] end_lane;

   always_comb begin
      // Only the first burst starts off a word boundary
      lead = first ? span_w'(xfer_addr[lane_w-1:0]) : '0;

      // Room left in the current page, measured from this burst's address
      to_bound = span_w'(dma_pkg::boundary_bytes) - span_w'(burst_addr[page_w-1:0]) - lead;
      to_limit = span_w'(dma_pkg::max_beats * dma_pkg::strb_w) - lead;

      cap  = (to_bound < to_limit) ? to_bound : to_limit;
      size = (remain < len_w'(cap)) ? remain : len_w'(cap);

      last_burst = (size == remain);

      // Beat count includes the lanes spilled by a misaligned start
      span_end  = len_w'(lead) + size - len_w'(1);
      burst_len = 8'(span_end >> lane_w);
   end

   // Strobes depend only on the transfer, not on the burst
   always_comb begin
      first_strb = {dma_pkg::strb_w{1'b1}} << xfer_addr[lane_w-1:0];

      // Lane holding the final byte of the transfer
      end_lane  = xfer_addr[lane_w-1:0] + xfer_len[lane_w-1:0] - lane_w'(1);
      last_strb = ~({dma_pkg::strb_w{1'b1}} << end_lane << 1);
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remain <= '0;
         first  <= 1'b0;
      end else if (start) begin
         remain <= xfer_len;
         first  <= 1'b1;
      end else if (burst_accept) begin
         remain <= remain - size;
         first  <= 1'b0;
      end
   end

   // Next burst address follows the beats just issued
   always_ff @(posedge clk) begin
      if (start) begin
         burst_addr <= {xfer_addr[addr_w-1:lane_w], {lane_w{1'b0}}};
      end else if (burst_accept) begin
         burst_addr <= burst_addr + ((addr_w'(burst_len) + addr_w'(1)) << lane_w);
      end
   end

endmodule

// File: verilog.f
dma_pkg.sv
transfer_controller.sv
dma_regs.sv
axi_write_master.sv
dma_write_top.sv
tb_dma_checker.sv
tb_dma_write.sv
